// File: source/aesPkg.sv
/*
 AES-128 shared widths, types and forward round transforms (encryption only).
 Byte 0 of a block sits in bits [127:120], and bytes fill the state column by column.
*/
package aesPkg;

    localparam int BlockWidth = 128;
    localparam int ByteWidth = 8;
    localparam int NumRounds = 10;
    localparam int RoundCountWidth = 4;

    typedef logic [BlockWidth-1:0] aesBlock;
    typedef logic [ByteWidth-1:0] aesByte;

    localparam aesByte RconInit = 8'h01;

    typedef enum logic [1:0] {
        Idle,
        Busy,
        Hold
    } roundState;

    // forward s-box, entry 0 in the top byte
    localparam aesByte [0:255] sboxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // multiply by two in GF(2^8)
    function automatic aesByte xtime(input aesByte b);
        return {b[ByteWidth-2:0], 1'b0} ^ (8'h1b & {ByteWidth{b[ByteWidth-1]}});
    endfunction

    function automatic logic [31:0] subWord(input logic [31:0] w);
        logic [31:0] result;
        for (int i = 0; i < 4; i++) begin
            result[ByteWidth*i +: ByteWidth] = sboxTable[w[ByteWidth*i +: ByteWidth]];
        end
        return result;
    endfunction

    function automatic aesBlock subBytes(input aesBlock s);
        aesBlock result;
        for (int i = 0; i < 16; i++) begin
            result[ByteWidth*i +: ByteWidth] = sboxTable[s[ByteWidth*i +: ByteWidth]];
        end
        return result;
    endfunction

    // row r moves left by r columns
    function automatic aesBlock shiftRows(input aesBlock s);
        aesBlock result;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                result[BlockWidth-1-ByteWidth*(4*c+r) -: ByteWidth] =
                    s[BlockWidth-1-ByteWidth*(4*((c+r)%4)+r) -: ByteWidth];
            end
        end
        return result;
    endfunction

    // each column times {02 03 01 01} circulant, 3a taken as xtime(a) ^ a
    function automatic aesBlock mixColumns(input aesBlock s);
        aesBlock result;
        logic [31:0] col;
        aesByte a0;
        aesByte a1;
        aesByte a2;
        aesByte a3;
        for (int c = 0; c < 4; c++) begin
            col = s[BlockWidth-1-32*c -: 32];
            a0 = col[31:24];
            a1 = col[23:16];
            a2 = col[15:8];
            a3 = col[7:0];
            result[BlockWidth-1-32*c -: 32] = {
                xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
            };
        end
        return result;
    endfunction

endpackage

// File: source/aesInputBuffer.sv
/*
 One-entry input slot. The producer must hold block and key while inValid waits.
 Whitening is done on the registered copy, so handover is one cycle after acceptance.
*/
`timescale 1ns/1ps

module aesInputBuffer
    import aesPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  aesBlock inBlock,
    input  aesBlock inKey,
    output logic    startValid,
    input  logic    startReady,
    output aesBlock startState,
    output aesBlock startKey
);

    logic    full;
    aesBlock blockReg;
    aesBlock keyReg;
    logic    accept;
    logic    handover;

    assign handover = full && startReady;
    // slot can refill in the same cycle it is handed over
    assign inReady = !full || startReady;
    assign accept = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (handover) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            blockReg <= inBlock;
            keyReg <= inKey;
        end
    end

    assign startValid = full;
    // add round key 0
    assign startState = blockReg ^ keyReg;
    assign startKey = keyReg;

endmodule

// File: source/aesKeySchedule.sv
/*
 AES-128 key expansion, one round key per step.
 roundKey is the expansion of the held key, so it is valid in the cycle after load or step.
*/
`timescale 1ns/1ps

module aesKeySchedule
    import aesPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    keyLoad,
    input  logic    keyStep,
    input  aesBlock startKey,
    output aesBlock roundKey
);

    aesBlock     currentKey;
    aesByte      rcon;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] temp;
    aesBlock     nextKey;

    always_comb begin
        w0 = currentKey[127:96];
        w1 = currentKey[95:64];
        w2 = currentKey[63:32];
        w3 = currentKey[31:0];
        // RotWord then SubWord, rcon goes into the top byte
        temp = subWord({w3[23:0], w3[31:24]}) ^ {rcon, 24'h000000};
        nextKey[127:96] = w0 ^ temp;
        nextKey[95:64] = w1 ^ nextKey[127:96];
        nextKey[63:32] = w2 ^ nextKey[95:64];
        nextKey[31:0] = w3 ^ nextKey[63:32];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rcon <= RconInit;
        end else if (keyLoad) begin
            rcon <= RconInit;
        end else if (keyStep) begin
            rcon <= xtime(rcon);
        end
    end

    always_ff @(posedge clk) begin
        if (keyLoad) begin
            currentKey <= startKey;
        end else if (keyStep) begin
            currentKey <= nextKey;
        end
    end

    assign roundKey = nextKey;

endmodule

// File: source/aesRoundEngine.sv
/*
 Iterative AES-128 rounds, one full round per clock, ten Busy cycles per block.
 The result waits in Hold until outReady. No new block is taken until then.
*/
`timescale 1ns/1ps

module aesRoundEngine
    import aesPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    startValid,
    output logic    startReady,
    input  aesBlock startState,
    output logic    keyLoad,
    output logic    keyStep,
    input  aesBlock roundKey,
    output logic    outValid,
    input  logic    outReady,
    output aesBlock outBlock
);

    roundState                  fsmState;
    logic [RoundCountWidth-1:0] roundCount;
    aesBlock                    stateReg;
    aesBlock                    afterShift;
    aesBlock                    roundResult;
    logic                       startXfer;
    logic                       lastRound;

    assign startReady = (fsmState == Idle);
    assign startXfer = startValid && startReady;
    assign lastRound = (roundCount == RoundCountWidth'(NumRounds));

    assign keyLoad = startXfer;
    assign keyStep = (fsmState == Busy);

    // final round has no MixColumns
    always_comb begin
        afterShift = shiftRows(subBytes(stateReg));
        if (lastRound) begin
            roundResult = afterShift ^ roundKey;
        end else begin
            roundResult = mixColumns(afterShift) ^ roundKey;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fsmState <= Idle;
            roundCount <= '0;
        end else begin
            case (fsmState)
                Idle: begin
                    if (startXfer) begin
                        fsmState <= Busy;
                        roundCount <= RoundCountWidth'(1);
                    end
                end
                Busy: begin
                    if (lastRound) begin
                        fsmState <= Hold;
                    end else begin
                        roundCount <= roundCount + 1'b1;
                    end
                end
                Hold: begin
                    if (outReady) begin
                        fsmState <= Idle;
                    end
                end
                default: begin
                    fsmState <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startXfer) begin
            stateReg <= startState;
        end else if (fsmState == Busy) begin
            stateReg <= roundResult;
        end
    end

    assign outValid = (fsmState == Hold);
    // not masked, only meaningful while outValid is high
    assign outBlock = stateReg;

endmodule

// File: source/aesEncryptTop.sv
/*
 AES-128 encryption core with valid/ready streams on input and output.
 Latency is 11 cycles from acceptance when idle, and up to two blocks are in flight.
*/
`timescale 1ns/1ps

module aesEncryptTop
    import aesPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  aesBlock inBlock,
    input  aesBlock inKey,
    output logic    outValid,
    input  logic    outReady,
    output aesBlock outBlock
);

    logic    startValid;
    logic    startReady;
    aesBlock startState;
    aesBlock startKey;
    logic    keyLoad;
    logic    keyStep;
    aesBlock roundKey;

    aesInputBuffer inputBuffer (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inReady    (inReady),
        .inBlock    (inBlock),
        .inKey      (inKey),
        .startValid (startValid),
        .startReady (startReady),
        .startState (startState),
        .startKey   (startKey)
    );

    aesKeySchedule keySchedule (
        .clk      (clk),
        .rst      (rst),
        .keyLoad  (keyLoad),
        .keyStep  (keyStep),
        .startKey (startKey),
        .roundKey (roundKey)
    );

    aesRoundEngine roundEngine (
        .clk        (clk),
        .rst        (rst),
        .startValid (startValid),
        .startReady (startReady),
        .startState (startState),
        .keyLoad    (keyLoad),
        .keyStep    (keyStep),
        .roundKey   (roundKey),
        .outValid   (outValid),
        .outReady   (outReady),
        .outBlock   (outBlock)
    );

endmodule

// File: sim/aesEncrypt_props.sv
/*
 Stream handshake checks, bound into every aesEncryptTop.
*/
`timescale 1ns/1ps

module aesEncryptProps
    import aesPkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    inValid,
    input aesBlock inBlock,
    input logic    outValid,
    input logic    outReady,
    input aesBlock outBlock
);

    int failCount = 0;

    // a stalled result keeps both valid and data
    outputHeld: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outBlock))
        else begin
            $error("outValid or outBlock changed while outReady was low");
            failCount++;
        end

    inputKnown: assert property (@(posedge clk) disable iff (rst)
        inValid |-> !$isunknown(inBlock))
        else begin
            $error("inBlock has unknown bits while inValid is high");
            failCount++;
        end

    resetClearsOut: assert property (@(posedge clk) rst |=> !outValid)
        else begin
            $error("outValid high in the cycle after reset");
            failCount++;
        end

endmodule

bind aesEncryptTop aesEncryptProps propsCheck (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inBlock  (inBlock),
    .outValid (outValid),
    .outReady (outReady),
    .outBlock (outBlock)
);

// File: sim/aesEncryptTb.sv
/*
 Reads key, plaintext and ciphertext triples from sim/aesPatterns.hex, run from the project root.
 NumPatterns must match the number of data lines in that file.
*/
`timescale 1ns/1ps

module aesEncryptTb
    import aesPkg::*;
();

    localparam int NumPatterns = 12;
    localparam int ResetCycles = 16;
    localparam int ExpectedLatency = 11;
    localparam int MaxInFlight = 2;
    localparam int MarginCycles = 300;
    localparam int WatchdogCycles = NumPatterns * 40 + ResetCycles + MarginCycles;
    localparam logic [31:0] Seed = 32'h04f7_5d5a;

    logic    clk;
    logic    rst;
    logic    inValid;
    logic    inReady;
    aesBlock inBlock;
    aesBlock inKey;
    logic    outValid;
    logic    outReady;
    aesBlock outBlock;

    aesBlock     patternMem [0:3*NumPatterns-1];
    aesBlock     expectQ [$];
    logic [31:0] rngState;
    logic        randomReady;
    int          cycleCount;
    int          acceptCount;
    int          outCount;
    int          acceptCycle;
    int          outCycle;
    int          errorCount;
    int          testCount;
    int          testsOk;

    aesEncryptTop dut_i (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inBlock  (inBlock),
        .inKey    (inKey),
        .outValid (outValid),
        .outReady (outReady),
        .outBlock (outBlock)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // outReady is high unless the back-pressure test is running
    always @(posedge clk) begin
        if (randomReady) begin
            rngState = nextRandom(rngState);
            outReady <= rngState[7];
        end else begin
            outReady <= 1'b1;
        end
    end

    // handshake monitor and scoreboard
    always @(posedge clk) begin
        aesBlock expected;
        cycleCount = cycleCount + 1;
        if (!rst && inValid && inReady) begin
            acceptCount = acceptCount + 1;
            acceptCycle = cycleCount;
        end
        if (!rst && outValid && outReady) begin
            outCycle = cycleCount;
            outCount = outCount + 1;
            if (expectQ.size() == 0) begin
                $display("error: output transfer at cycle %0d with no block pending", cycleCount);
                errorCount++;
            end else begin
                expected = expectQ.pop_front();
                if (outBlock !== expected) begin
                    $display("[FAIL] outBlock expected %h got %h", expected, outBlock);
                    errorCount++;
                end
            end
        end
        if (acceptCount - outCount > MaxInFlight) begin
            $display("error: %0d blocks accepted but only %0d delivered, too many in flight",
                     acceptCount, outCount);
            errorCount++;
        end
    end

    // call right after a rising edge, returns on the acceptance edge
    task automatic sendPattern(input int idx);
        inValid <= 1'b1;
        inKey <= patternMem[3*idx];
        inBlock <= patternMem[3*idx+1];
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        expectQ.push_back(patternMem[3*idx+2]);
    endtask

    task automatic runStream(input logic reverse);
        int startAccept;
        int startOut;
        int idx;
        startAccept = acceptCount;
        startOut = outCount;
        for (int i = 0; i < NumPatterns; i++) begin
            idx = reverse ? NumPatterns - 1 - i : i;
            sendPattern(idx);
        end
        inValid <= 1'b0;
        wait (outCount >= startOut + NumPatterns);
        // a stray extra block would surface within one block time
        repeat (ExpectedLatency + 2) @(posedge clk);
        if (outCount - startOut != acceptCount - startAccept) begin
            $display("error: %0d blocks accepted but %0d delivered",
                     acceptCount - startAccept, outCount - startOut);
            errorCount++;
        end
        if (expectQ.size() != 0) begin
            $display("error: %0d expected blocks never came out", expectQ.size());
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsAtStart);
        int newErrors;
        newErrors = errorCount - errorsAtStart;
        testCount++;
        if (newErrors == 0) begin
            testsOk++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, newErrors);
        end
    endtask

    initial begin
        int   errorsAtStart;
        int   latency;
        int   totalErrors;
        logic loadOk;
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inBlock = '0;
        inKey = '0;
        outReady = 1'b0;
        randomReady = 1'b0;
        rngState = Seed;
        cycleCount = 0;
        acceptCount = 0;
        outCount = 0;
        acceptCycle = 0;
        outCycle = 0;
        errorCount = 0;
        testCount = 0;
        testsOk = 0;
        loadOk = 1'b1;

        $readmemh("sim/aesPatterns.hex", patternMem);
        for (int i = 0; i < 3 * NumPatterns; i++) begin
            if ($isunknown(patternMem[i])) begin
                loadOk = 1'b0;
            end
        end
        if (!loadOk) begin
            $display("error: pattern file sim/aesPatterns.hex is missing or incomplete");
            errorCount++;
        end

        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;

        if (loadOk) begin
            errorsAtStart = errorCount;
            @(posedge clk);
            if (inReady !== 1'b1) begin
                $display("[FAIL] inReady expected %h got %h", 1'b1, inReady);
                errorCount++;
            end
            if (outValid !== 1'b0) begin
                $display("[FAIL] outValid expected %h got %h", 1'b0, outValid);
                errorCount++;
            end
            reportTest("reset state", errorsAtStart);

            errorsAtStart = errorCount;
            sendPattern(0);
            inValid <= 1'b0;
            wait (outCount >= 1);
            @(posedge clk);
            // outValid rose on the edge before the one that sampled it
            latency = outCycle - acceptCycle - 1;
            if (latency != ExpectedLatency) begin
                $display("[FAIL] outValid latency expected %h got %h", ExpectedLatency, latency);
                errorCount++;
            end
            reportTest("single block", errorsAtStart);

            errorsAtStart = errorCount;
            runStream(1'b0);
            reportTest("stream", errorsAtStart);

            errorsAtStart = errorCount;
            randomReady <= 1'b1;
            runStream(1'b0);
            randomReady <= 1'b0;
            reportTest("back-pressure", errorsAtStart);

            errorsAtStart = errorCount;
            for (int i = 1; i < NumPatterns; i++) begin
                if (patternMem[3*i] == patternMem[3*(i-1)]) begin
                    $display("error: patterns %0d and %0d share a key", i - 1, i);
                    errorCount++;
                end
            end
            runStream(1'b1);
            reportTest("key change", errorsAtStart);
        end

        totalErrors = errorCount + dut_i.propsCheck.failCount;
        $display("summary: %0d of %0d tests ok, %0d check errors, %0d assertion failures",
                 testsOk, testCount, errorCount, dut_i.propsCheck.failCount);
        if (totalErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("error: watchdog expired after %0d cycles, the DUT stopped handshaking",
                 WatchdogCycles);
        $display("tests failed");
        $finish;
    end

endmodule

// File: sim/aesPatterns.hex
// columns: key, plaintext, expected ciphertext (128-bit hex, byte 0 leftmost)
// FIPS-197 appendix vectors, ECB mode examples and known-answer vectors
// consecutive lines use different keys
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589

// File: aesEncrypt.f
source/aesPkg.sv
source/aesInputBuffer.sv
source/aesKeySchedule.sv
source/aesRoundEngine.sv
source/aesEncryptTop.sv
sim/aesEncrypt_props.sv
sim/aesEncryptTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := aesEncryptTb
FILELIST   := aesEncrypt.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary -j 0 --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
